//--- design/ex_macros.svh
/*
  Global widths for the execute stage.
  RV32 only, so XLEN is fixed at 32 and the lane count at 4.
  The byte-lane logic expects MEM_UNIT * 8 == XLEN.
*/
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// ----------------------------------------------------------------------
// datapath
// ----------------------------------------------------------------------
`define XLEN        32  // data and address width

`define REG_ADDR_W  5   // x0..x31

// ----------------------------------------------------------------------
// memory and shifter
// ----------------------------------------------------------------------
`define MEM_UNIT    4   // byte lanes per word

// low bits of op2 used as shift amount
`define SHAMT_W     5

`endif

//--- design/rv_isa_pkg.sv
/*
  RV32I base encodings as seen by the execute stage.
  M-extension only as a funct7 value so its encodings can be rejected.
  inst_t uses the R-type field layout; other formats slice the raw word.
*/
`default_nettype none

`include "ex_macros.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_I      = 7'b0010011,  // register-immediate alu
        OPC_R      = 7'b0110011,  // register-register alu and muldiv
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    // 32-bit instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } inst_t;

    // ----------------------------------------------------------------------
    // funct3 per instruction group
    // ----------------------------------------------------------------------
    // alu, shared by OPC_I and OPC_R
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // funct7
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- design/ex_pkg.sv
/*
  Bundles crossing the execute stage boundary.
  All output bundles are all-zero when idle; consumers may rely on it.
  The fetch side adds jump base and offset itself.
*/
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

    import rv_isa_pkg::*;

    // from the decode stage, one per clock
    typedef struct packed {
        logic      valid;
        inst_t     inst;
        word_t     instaddr;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     op1;       // decoder-selected operands
        word_t     op2;
        logic      regs_wen;
        reg_addr_t rd_addr;
    } ex_in_t;

    // ----------------------------------------------------------------------
    // stage outputs
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      wen;
        reg_addr_t rd_addr;
        word_t     rd_data;
    } wb_t;

    typedef struct packed {
        logic                 cs;
        logic                 we;
        logic [`MEM_UNIT-1:0] wem;   // byte lane write mask
        word_t                din;
        word_t                addr;
    } mem_req_t;

    typedef struct packed {
        logic  en;
        word_t base;
        word_t ofst;
    } jump_t;

    // op1 vs op2, shared by slt and branches
    typedef struct packed {
        logic eq;
        logic lt_s;
        logic lt_u;
    } cmp_flags_t;

endpackage

`default_nettype wire

//--- design/ex_alu.sv
/*
  Integer ALU of the execute stage, purely combinational.
  One adder serves alu ops, links, lui/auipc and the load/store address.
  M-extension encodings give rd_data of zero; wen still follows the input.
*/
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_alu
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  ex_in_t     ex_in_i,
    output wb_t        wb_o,
    output word_t      sum_o,
    output cmp_flags_t cmp_o
);

    word_t               op1;
    word_t               op2;
    logic [`SHAMT_W-1:0] shamt;

    word_t op_sum;
    word_t op_diff;
    word_t op_or;
    word_t op_xor;
    word_t op_and;
    word_t sl_shift;
    word_t sr_shift;
    word_t sr_mask;
    word_t sra_shift;

    logic  is_r;
    logic  funct7_alt;   // funct7 not zero, sub or sra
    word_t rd_data;

    assign op1   = ex_in_i.op1;
    assign op2   = ex_in_i.op2;
    assign shamt = op2[`SHAMT_W-1:0];

    // ----------------------------------------------------------------------
    // shared operators
    // ----------------------------------------------------------------------
    assign op_sum  = op1 + op2;
    assign op_diff = op1 - op2;
    assign op_or   = op1 | op2;
    assign op_xor  = op1 ^ op2;
    assign op_and  = op1 & op2;

    assign sl_shift  = op1 << shamt;
    assign sr_shift  = op1 >> shamt;
    assign sr_mask   = {`XLEN{1'b1}} >> shamt;
    // fill vacated msbs with the sign bit
    assign sra_shift = sr_shift | ({`XLEN{op1[`XLEN-1]}} & ~sr_mask);

    assign cmp_o.eq   = (op1 == op2);
    assign cmp_o.lt_s = ($signed(op1) < $signed(op2));
    assign cmp_o.lt_u = (op1 < op2);

    // ----------------------------------------------------------------------
    // result select
    // ----------------------------------------------------------------------
    assign is_r       = (ex_in_i.inst.opcode == OPC_R);
    assign funct7_alt = (ex_in_i.inst.funct7 != FUNCT7_BASE);

    always_comb begin
        rd_data = '0;
        case (ex_in_i.inst.opcode)
            OPC_I, OPC_R: begin
                if (!(is_r && ex_in_i.inst.funct7 == FUNCT7_MULDIV)) begin
                    case (ex_in_i.inst.funct3)
                        F3_ADD_SUB: rd_data = (is_r && funct7_alt) ? op_diff : op_sum;
                        F3_SLL:     rd_data = sl_shift;
                        F3_SLT:     rd_data = {{(`XLEN-1){1'b0}}, cmp_o.lt_s};
                        F3_SLTU:    rd_data = {{(`XLEN-1){1'b0}}, cmp_o.lt_u};
                        F3_XOR:     rd_data = op_xor;
                        F3_SRL_SRA: rd_data = funct7_alt ? sra_shift : sr_shift;
                        F3_OR:      rd_data = op_or;
                        F3_AND:     rd_data = op_and;
                        default:    rd_data = '0;
                    endcase
                end
            end
            // link value and upper immediates come pre-formed in op1/op2
            OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC: rd_data = op_sum;
            default: rd_data = '0;
        endcase
    end

    assign wb_o.wen     = ex_in_i.regs_wen;
    assign wb_o.rd_addr = ex_in_i.rd_addr;
    assign wb_o.rd_data = rd_data;

    assign sum_o = op_sum;  // effective address for the lsu

endmodule

`default_nettype wire

//--- design/ex_branch.sv
/*
  Jump and branch resolution, combinational.
  Only base and offset are produced; the target add is left to fetch.
  Branch conditions come from the ALU compare flags on op1 and op2.
*/
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_branch
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  ex_in_t     ex_in_i,
    input  cmp_flags_t cmp_i,
    output jump_t      jump_o
);

    logic [31:0] iw;       // raw instruction bits
    word_t       imm_i;
    word_t       imm_b;
    word_t       imm_j;
    jump_t       jump;

    assign iw = ex_in_i.inst;

    // ----------------------------------------------------------------------
    // sign-extended immediates
    // ----------------------------------------------------------------------
    assign imm_i = {{(`XLEN-12){iw[31]}}, iw[31:20]};

    assign imm_b = {{(`XLEN-13){iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};

    assign imm_j = {{(`XLEN-21){iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

    // ----------------------------------------------------------------------
    // decision
    // ----------------------------------------------------------------------
    always_comb begin
        jump = '0;
        case (ex_in_i.inst.opcode)
            OPC_JAL: begin
                jump.en   = 1'b1;
                jump.base = ex_in_i.instaddr;
                jump.ofst = imm_j;
            end
            OPC_JALR: begin
                jump.en   = 1'b1;
                jump.base = ex_in_i.rs1_data;
                jump.ofst = imm_i;
            end
            OPC_BRANCH: begin
                // base/ofst are driven even when not taken
                jump.base = ex_in_i.instaddr;
                jump.ofst = imm_b;
                case (ex_in_i.inst.funct3)
                    F3_BEQ:  jump.en = cmp_i.eq;
                    F3_BNE:  jump.en = ~cmp_i.eq;
                    F3_BLT:  jump.en = cmp_i.lt_s;
                    F3_BGE:  jump.en = ~cmp_i.lt_s;
                    F3_BLTU: jump.en = cmp_i.lt_u;
                    F3_BGEU: jump.en = ~cmp_i.lt_u;
                    default: begin
                        jump = '0;   // reserved funct3
                    end
                endcase
            end
            default: jump = '0;
        endcase
    end

    assign jump_o = jump;

endmodule

`default_nettype wire

//--- design/ex_lsu_req.sv
/*
  Load/store request builder, combinational.
  Store data is placed on its byte lanes here; the memory stores per wem.
  Misaligned halves go to the upper lanes; no misalignment trap exists.
  Loads return data elsewhere, this block only issues the address.
*/
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_lsu_req
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  ex_in_t   ex_in_i,
    input  word_t    addr_i,     // op1 + op2 from the alu adder
    output mem_req_t mem_o
);

    localparam int HALF_W = `XLEN / 2;
    localparam int HALF_L = `MEM_UNIT / 2;

    logic [1:0] lane;
    mem_req_t   req;

    assign lane = addr_i[1:0];

    always_comb begin
        req = '0;
        case (ex_in_i.inst.opcode)
            OPC_LOAD: begin
                req.cs   = 1'b1;
                req.addr = addr_i;  // we and wem stay low
            end
            OPC_STORE: begin
                req.cs   = 1'b1;
                req.we   = 1'b1;
                req.addr = addr_i;
                case (ex_in_i.inst.funct3)
                    F3_SB: begin
                        // byte moves to lane addr[1:0]
                        req.din = word_t'(ex_in_i.rs2_data[7:0]) << {lane, 3'b000};
                        req.wem = `MEM_UNIT'(1) << lane;
                    end
                    F3_SH: begin
                        if (lane == 2'b00) begin
                            req.din = word_t'(ex_in_i.rs2_data[HALF_W-1:0]);
                            req.wem = {{HALF_L{1'b0}}, {HALF_L{1'b1}}};
                        end else begin
                            req.din = word_t'(ex_in_i.rs2_data[HALF_W-1:0]) << HALF_W;
                            req.wem = {{HALF_L{1'b1}}, {HALF_L{1'b0}}};
                        end
                    end
                    F3_SW: begin
                        req.din = ex_in_i.rs2_data;
                        req.wem = {`MEM_UNIT{1'b1}};
                    end
                    default: begin
                        // unknown width, cs/we stay up with nothing written
                        req.din = '0;
                        req.wem = '0;
                    end
                endcase
            end
            default: req = '0;
        endcase
    end

    assign mem_o = req;

endmodule

`default_nettype wire

//--- design/ex_stage_reg.sv
/*
  Stage boundary register for any packed bundle type.
  Loads zero whenever valid_i is low, so a bubble reads as all-zero.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic valid_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (valid_i) begin
            q_o <= d_i;
        end else begin
            q_o <= '0;  // bubble
        end
    end

endmodule

`default_nettype wire

//--- design/ex_top.sv
/*
  Execute stage of a small RV32I core, one instruction per clock.
  No stall or back-pressure; every result appears one cycle after input.
  Multiply/divide is not supported.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_top
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ex_in_t   ex_in_i,
    output wb_t      wb_o,
    output mem_req_t mem_req_o,
    output jump_t    jump_o
);

    wb_t        wb_d;
    mem_req_t   mem_d;
    jump_t      jump_d;
    word_t      alu_sum;    // shared adder output
    cmp_flags_t alu_cmp;

    // ----------------------------------------------------------------------
    // combinational units
    // ----------------------------------------------------------------------
    ex_alu u_alu (
        .ex_in_i (ex_in_i),
        .wb_o    (wb_d),
        .sum_o   (alu_sum),
        .cmp_o   (alu_cmp)
    );

    ex_branch u_branch (
        .ex_in_i (ex_in_i),
        .cmp_i   (alu_cmp),
        .jump_o  (jump_d)
    );

    ex_lsu_req u_lsu_req (
        .ex_in_i (ex_in_i),
        .addr_i  (alu_sum),
        .mem_o   (mem_d)
    );

    // ----------------------------------------------------------------------
    // stage boundary
    // ----------------------------------------------------------------------
    ex_stage_reg #(.T(wb_t)) u_wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_in_i.valid),
        .d_i      (wb_d),
        .q_o      (wb_o)
    );

    ex_stage_reg #(.T(mem_req_t)) u_mem_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_in_i.valid),
        .d_i      (mem_d),
        .q_o      (mem_req_o)
    );

    ex_stage_reg #(.T(jump_t)) u_jump_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ex_in_i.valid),
        .d_i      (jump_d),
        .q_o      (jump_o)
    );

endmodule

`default_nettype wire

//--- tests/ex_tb.sv
/*
  Random self-checking testbench for ex_top.
  Stimulus comes from an LFSR, and op1/op2 are chosen per opcode like a simple decoder.
  Unknown opcodes are issued with regs_wen and rd_addr cleared.
  Each output is checked one cycle after its input, at the falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_tb
    import rv_isa_pkg::*;
    import ex_pkg::*;
();

    localparam int         N_ITEMS       = 3000;
    localparam int         DRAIN_TIMEOUT = 20;          // cycles
    localparam logic [6:0] OPC_UNKNOWN   = 7'b0001111;  // fence is not executed

    typedef struct packed {
        wb_t      wb;
        mem_req_t mem;
        jump_t    jmp;
    } exp_t;

    logic         clk;
    logic         arst_n_i;
    ex_in_t       ex_in;
    wb_t          wb_o;
    mem_req_t     mem_req_o;
    jump_t        jump_o;
    logic [31:0]  lfsr_state  = 32'd84580;
    int           sent_cnt    = 0;
    int           checked_cnt = 0;
    int           wb_errs     = 0;
    int           mem_errs    = 0;
    int           jump_errs   = 0;

    ex_top uut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ex_in_i   (ex_in),
        .wb_o      (wb_o),
        .mem_req_o (mem_req_o),
        .jump_o    (jump_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
    // ----------------------------------------------------------------------
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // biased toward small, negative and large values
    function automatic word_t pick_operand();
        word_t v;
        case (rand_bits(2))
            2'd0:    v = rand_bits(5);
            2'd1:    v = rand_bits(31) | 32'h8000_0000;
            default: v = rand_bits(32);
        endcase
        return v;
    endfunction

    function automatic ex_in_t gen_item();
        ex_in_t      x;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [6:0]  f7;
        word_t       imm_i;
        word_t       imm_s;
        case (rand_bits(4) % 10)
            0:       opc = OPC_I;
            1:       opc = OPC_R;
            2:       opc = OPC_JAL;
            3:       opc = OPC_JALR;
            4:       opc = OPC_BRANCH;
            5:       opc = OPC_LUI;
            6:       opc = OPC_AUIPC;
            7:       opc = OPC_LOAD;
            8:       opc = OPC_STORE;
            default: opc = OPC_UNKNOWN;
        endcase
        case (rand_bits(2))
            2'd0:    f7 = FUNCT7_BASE;
            2'd1:    f7 = FUNCT7_ALT;
            2'd2:    f7 = FUNCT7_MULDIV;
            default: f7 = 7'(rand_bits(7));
        endcase
        w[31:25] = f7;
        w[24:7]  = 18'(rand_bits(18));  // rs2, rs1, funct3, rd
        w[6:0]   = opc;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};

        x          = '0;
        x.valid    = (rand_bits(3) != 0);  // about one bubble in eight
        x.inst     = inst_t'(w);
        x.instaddr = rand_bits(30) << 2;
        x.rs1_data = pick_operand();
        x.rs2_data = (rand_bits(2) == 0) ? x.rs1_data : pick_operand();
        x.op1      = x.rs1_data;
        x.op2      = x.rs2_data;
        case (opc)
            OPC_I, OPC_LOAD: x.op2 = imm_i;
            OPC_STORE:       x.op2 = imm_s;
            OPC_JAL, OPC_JALR: begin
                x.op1 = x.instaddr;  // link is pc + 4
                x.op2 = 32'd4;
            end
            OPC_LUI: begin
                x.op1 = '0;
                x.op2 = {w[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                x.op1 = x.instaddr;
                x.op2 = {w[31:12], 12'b0};
            end
            default: ;
        endcase
        x.regs_wen = !(opc inside {OPC_BRANCH, OPC_STORE, OPC_UNKNOWN});
        x.rd_addr  = x.regs_wen ? w[11:7] : '0;
        return x;
    endfunction

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic exp_t ref_ex(input ex_in_t x);
        exp_t        e;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        word_t       a;
        word_t       b;
        word_t       sum;
        logic [4:0]  sh;
        logic        lt_s;
        logic        lt_u;
        logic [3:0]  m;
        e = '0;
        if (!x.valid) begin
            return e;
        end
        w    = x.inst;
        opc  = w[6:0];
        f3   = w[14:12];
        f7   = w[31:25];
        a    = x.op1;
        b    = x.op2;
        sum  = a + b;
        sh   = b[4:0];
        lt_s = ($signed(a) < $signed(b));
        lt_u = (a < b);

        e.wb.wen     = x.regs_wen;
        e.wb.rd_addr = x.rd_addr;
        if (opc == OPC_I || (opc == OPC_R && f7 != FUNCT7_MULDIV)) begin
            case (f3)
                F3_ADD_SUB: e.wb.rd_data = (opc == OPC_R && f7 != 0) ? a - b : sum;
                F3_SLL:     e.wb.rd_data = a << sh;
                F3_SLT:     e.wb.rd_data = {31'b0, lt_s};
                F3_SLTU:    e.wb.rd_data = {31'b0, lt_u};
                F3_XOR:     e.wb.rd_data = a ^ b;
                F3_SRL_SRA: e.wb.rd_data = (f7 != 0) ? $unsigned($signed(a) >>> sh) : a >> sh;
                F3_OR:      e.wb.rd_data = a | b;
                default:    e.wb.rd_data = a & b;
            endcase
        end else if (opc inside {OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC}) begin
            e.wb.rd_data = sum;
        end

        if (opc == OPC_JAL) begin
            e.jmp = {1'b1, x.instaddr,
                     {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}};
        end else if (opc == OPC_JALR) begin
            e.jmp = {1'b1, x.rs1_data, {{20{w[31]}}, w[31:20]}};
        end else if (opc == OPC_BRANCH && f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE,
                                                     F3_BLTU, F3_BGEU}) begin
            e.jmp.base = x.instaddr;
            e.jmp.ofst = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            // odd funct3 inverts the condition of its pair
            case (f3[2:1])
                2'b00:   e.jmp.en = (a == b) ^ f3[0];
                2'b10:   e.jmp.en = lt_s ^ f3[0];
                default: e.jmp.en = lt_u ^ f3[0];
            endcase
        end

        if (opc == OPC_LOAD || opc == OPC_STORE) begin
            e.mem.cs   = 1'b1;
            e.mem.we   = (opc == OPC_STORE);
            e.mem.addr = sum;
        end
        if (opc == OPC_STORE) begin
            case (f3)
                F3_SB:   m = 4'b0001 << sum[1:0];
                F3_SH:   m = (sum[1:0] == 2'b00) ? 4'b0011 : 4'b1100;
                F3_SW:   m = 4'b1111;
                default: m = 4'b0000;
            endcase
            e.mem.wem = m;
            // replicate the store data, then keep only the enabled lanes
            case (f3)
                F3_SB:   e.mem.din = {4{x.rs2_data[7:0]}};
                F3_SH:   e.mem.din = {2{x.rs2_data[15:0]}};
                default: e.mem.din = x.rs2_data;
            endcase
            e.mem.din = e.mem.din & {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        end
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // check each output one cycle after its input is sampled
    // ----------------------------------------------------------------------
    initial begin : compare_outputs
        exp_t  exp;
        logic  in_reset;
        string tname;
        forever begin
            @(posedge clk);
            in_reset = !arst_n_i;
            if (in_reset) begin
                exp   = '0;
                tname = "reset";
            end else begin
                exp   = ref_ex(ex_in);
                tname = ex_in.valid ? $sformatf("opc_%h", ex_in.inst[6:0]) : "bubble";
            end
            @(negedge clk);
            if (wb_o !== exp.wb) begin
                wb_errs++;
                $display("ERROR %s wb item %0d: expected %h, actual %h",
                         tname, checked_cnt, exp.wb, wb_o);
            end
            if (mem_req_o !== exp.mem) begin
                mem_errs++;
                $display("ERROR %s mem_req item %0d: expected %h, actual %h",
                         tname, checked_cnt, exp.mem, mem_req_o);
            end
            if (jump_o !== exp.jmp) begin
                jump_errs++;
                $display("ERROR %s jump item %0d: expected %h, actual %h",
                         tname, checked_cnt, exp.jmp, jump_o);
            end
            if (!in_reset) begin
                checked_cnt++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin : run_items
        int wait_cycles;
        arst_n_i = 1'b0;
        ex_in    = '0;
        // random items during reset must not leak out
        repeat (8) begin
            @(posedge clk);
            ex_in <= gen_item();
        end
        arst_n_i <= 1'b1;
        sent_cnt = 1;
        while (sent_cnt < N_ITEMS) begin
            @(posedge clk);
            ex_in <= gen_item();
            sent_cnt++;
        end
        @(posedge clk);
        ex_in <= '0;  // idle tail
        sent_cnt++;

        wait_cycles = 0;
        while (checked_cnt < sent_cnt && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        $display("errors: wb %0d, mem_req %0d, jump %0d, items checked %0d of %0d",
                 wb_errs, mem_errs, jump_errs, checked_cnt, sent_cnt);
        if (checked_cnt < sent_cnt) begin
            $display("timeout: not all items were checked after the last input");
            $display("Result: FAILED");
        end else if (wb_errs + mem_errs + jump_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/rv_isa_pkg.sv
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_lsu_req.sv
design/ex_stage_reg.sv
design/ex_top.sv
tests/ex_tb.sv

//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - design

sources:
  - design/rv_isa_pkg.sv
  - design/ex_pkg.sv
  - design/ex_alu.sv
  - design/ex_branch.sv
  - design/ex_lsu_req.sv
  - design/ex_stage_reg.sv
  - design/ex_top.sv
  - target: test
    files:
      - tests/ex_tb.sv
